/* bp_pkg.sv */
package bp_pkg;

  // ####################################################################
  // Sizes of the byte pipe register subsystem.
  // ####################################################################

  localparam int BP_DATA_W       = 8;   // Width of every byte on both streams.
  localparam int BP_ADDR_FIELD_W = 7;   // Address field of a command byte.
  localparam int BP_N_REG        = 64;  // Implemented registers, at most 128.
  localparam int BP_FIFO_DEPTH   = 4;   // Entries in the host input FIFO.

  // ####################################################################
  // Byte formats.
  // ####################################################################

  // A byte that starts a transaction.
  // The write flag sits in the top bit and the address fills the rest.
  typedef struct packed {
    logic                       wr;    // High for a write, low for a read.
    logic [BP_ADDR_FIELD_W-1:0] addr;  // Register address of the command.
  } bp_cmd_t;

  // One byte seen two ways.
  // A byte is a command when it opens a transaction and plain data when it
  // carries write data or reply data.
  // Both views cover the same eight bits.
  typedef union packed {
    bp_cmd_t              cmd;   // Command view, used on the first byte.
    logic [BP_DATA_W-1:0] data;  // Data view, used on write and reply bytes.
  } bp_byte_u;

  // The two views must match the byte width for the union to be legal.
  // The command struct is 1 + BP_ADDR_FIELD_W bits, which equals BP_DATA_W.
  // A read command names the address whose contents come back one
  // transaction later.
  // A write command is followed by exactly one data byte.
  // Addresses at or above the register count read as zero.
  // Writes to such addresses change nothing.

endpackage

/* bp_byte_fifo.sv */
`timescale 1ns/1ps

module bp_byte_fifo import bp_pkg::*; #(
  parameter int DEPTH = BP_FIFO_DEPTH  // Number of byte entries.
) (
  input  logic                 i_clk,
  input  logic                 i_rst_n,

  input  logic [BP_DATA_W-1:0] i_data,   // Byte from the host.
  input  logic                 i_valid,  // Host byte is present.
  output logic                 o_ready,  // FIFO can take the host byte.

  output logic [BP_DATA_W-1:0] o_data,   // Oldest stored byte.
  output logic                 o_valid,  // At least one byte is stored.
  input  logic                 i_ready   // Downstream takes the oldest byte.
);

  // ####################################################################
  // Pointer and occupancy widths.
  // ####################################################################

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // Index into the buffer.
  localparam int CNT_W = $clog2(DEPTH + 1);                // Holds 0 up to DEPTH.

  logic [BP_DATA_W-1:0] buf_q [DEPTH];  // Byte storage, written on push only.
  logic [PTR_W-1:0]     wr_ptr_q;       // Next slot to write.
  logic [PTR_W-1:0]     rd_ptr_q;       // Slot of the oldest byte.
  logic [CNT_W-1:0]     count_q;        // Bytes currently stored.
  logic                 full;           // All slots occupied.
  logic                 push;           // Byte moves in at this edge.
  logic                 pop;            // Byte moves out at this edge.

  // ####################################################################
  // Handshakes.
  // ####################################################################

  assign full    = (count_q == CNT_W'(DEPTH));  // Every entry holds a byte.
  assign o_valid = (count_q != '0);             // Show-ahead, so any byte is visible.
  assign o_data  = buf_q[rd_ptr_q];             // Oldest byte goes out combinationally.

  // A full FIFO still accepts a byte when one leaves at the same edge.
  assign o_ready = !full || i_ready;

  assign push = i_valid && o_ready;  // Host byte is taken.
  assign pop  = o_valid && i_ready;  // Oldest byte is taken.

  // ####################################################################
  // Storage and pointers.
  // ####################################################################

  always_ff @(posedge i_clk) begin
    if (push) begin
      buf_q[wr_ptr_q] <= i_data;  // Store the host byte in the free slot.
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;  // Empty after reset.
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        // Wrap explicitly so any depth works, not only powers of two.
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;  // Fill by one.
        2'b01:   count_q <= count_q - 1'b1;  // Drain by one.
        default: count_q <= count_q;         // Both or neither keep the level.
      endcase
    end
  end

endmodule

/* bp_reg_mem.sv */
`timescale 1ns/1ps

module bp_reg_mem import bp_pkg::*; #(
  parameter int N_REG = BP_N_REG  // Implemented registers, 2 up to 128.
) (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_cg,        // Block advances only while high.

  input  bp_byte_u             i_bp_data,   // Command or write data byte.
  input  logic                 i_bp_valid,  // Input byte is present.
  output logic                 o_bp_ready,  // Block takes the input byte.

  output logic [BP_DATA_W-1:0] o_bp_data,   // Reply byte.
  output logic                 o_bp_valid,  // Reply byte is present.
  input  logic                 i_bp_ready   // Host takes the reply byte.
);

  // ####################################################################
  // Declarations.
  // ####################################################################

  localparam int ADDR_W = $clog2(N_REG);  // Bits that index the register array.

  logic [BP_DATA_W-1:0]       regs_q [N_REG];  // Register contents, not reset.
  logic                       wr_pend_q;       // Next byte is write data.
  logic [BP_ADDR_FIELD_W-1:0] addr_q;          // Address from the last command.
  logic                       in_range_q;      // Held address names a real register.
  logic                       rsp_valid_q;     // A reply waits for the host.
  logic [BP_DATA_W-1:0]       rsp_data_q;      // The waiting reply.

  logic                       in_acc;          // Input byte moves at this edge.
  logic                       out_acc;         // Reply byte moves at this edge.
  logic                       txn_cmd;         // Accepted byte is a command.
  logic                       wr_begin;        // Accepted byte is a write command.
  logic                       rd_cmd;          // Accepted byte is a read command.
  logic                       wr_end;          // Accepted byte is write data.
  logic                       rsp_load;        // A transaction ends at this edge.
  logic                       cmd_in_range;    // Incoming address is implemented.
  logic [ADDR_W-1:0]          reg_idx;         // Array index of the held address.
  logic [BP_DATA_W-1:0]       rd_word;         // Contents at the held address.

  // ####################################################################
  // Transaction decode.
  // ####################################################################

  // Host back-pressure passes straight to the FIFO, and a frozen block
  // refuses every byte so that nothing is dropped.
  assign o_bp_ready = i_bp_ready && i_cg;

  // A reply is hidden while the block is frozen, so the host cannot take
  // the same byte twice while the valid flag cannot clear.
  assign o_bp_valid = rsp_valid_q && i_cg;
  assign o_bp_data  = rsp_data_q;

  assign in_acc  = i_bp_valid && o_bp_ready;  // Implies i_cg is high.
  assign out_acc = o_bp_valid && i_bp_ready;  // Implies i_cg is high.

  assign txn_cmd  = in_acc && !wr_pend_q;             // First byte of a transaction.
  assign wr_begin = txn_cmd && i_bp_data.cmd.wr;      // Data byte follows.
  assign rd_cmd   = txn_cmd && !i_bp_data.cmd.wr;     // Single-byte transaction.
  assign wr_end   = in_acc && wr_pend_q;              // Second byte of a write.
  assign rsp_load = rd_cmd || wr_end;                 // Both end a transaction.

  // Compare one bit wider than the field so that N_REG of 128 fits.
  assign cmd_in_range = ({1'b0, i_bp_data.cmd.addr} < (BP_ADDR_FIELD_W + 1)'(N_REG));

  assign reg_idx = addr_q[ADDR_W-1:0];                      // Low bits pick the register.
  assign rd_word = in_range_q ? regs_q[reg_idx] : '0;       // Unimplemented reads as zero.

  // ####################################################################
  // Control state.
  // ####################################################################

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      wr_pend_q   <= 1'b0;  // Expect a command first.
      addr_q      <= '0;
      in_range_q  <= 1'b0;  // So the first read returns zero.
      rsp_valid_q <= 1'b0;
    end else if (i_cg) begin
      if (wr_begin) begin
        wr_pend_q <= 1'b1;  // Wait for the data byte.
      end else if (wr_end) begin
        wr_pend_q <= 1'b0;  // Write is complete.
      end

      if (txn_cmd) begin
        addr_q     <= i_bp_data.cmd.addr;  // Every command updates the held address.
        in_range_q <= cmd_in_range;
      end

      // A new reply wins over the departure of the old one at the same edge.
      if (rsp_load) begin
        rsp_valid_q <= 1'b1;
      end else if (out_acc) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  // ####################################################################
  // Register array and reply data.
  // ####################################################################

  always_ff @(posedge i_clk) begin
    if (i_cg && rsp_load) begin
      // The held address is read before this edge's command replaces it.
      // For a write the old contents come back, not the new byte.
      rsp_data_q <= rd_word;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_cg && wr_end && in_range_q) begin
      regs_q[reg_idx] <= i_bp_data.data;  // Out-of-range writes are dropped.
    end
  end

endmodule

/* bp_top.sv */
`timescale 1ns/1ps

module bp_top import bp_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_cg,        // Freezes the register block when low.

  input  logic [BP_DATA_W-1:0] i_bp_data,   // Host byte stream in.
  input  logic                 i_bp_valid,
  output logic                 o_bp_ready,

  output logic [BP_DATA_W-1:0] o_bp_data,   // Reply byte stream out.
  output logic                 o_bp_valid,
  input  logic                 i_bp_ready
);

  // ####################################################################
  // FIFO to register block stream.
  // ####################################################################

  logic [BP_DATA_W-1:0] fifo_data;   // Oldest buffered host byte.
  logic                 fifo_valid;  // FIFO holds at least one byte.
  logic                 mem_ready;   // Register block takes the byte.

  // ####################################################################
  // Host input buffer.
  // ####################################################################

  // Absorbs host bytes while the reply side stalls or the block is frozen.
  bp_byte_fifo #(
    .DEPTH   (BP_FIFO_DEPTH)
  ) u_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_data  (i_bp_data),
    .i_valid (i_bp_valid),
    .o_ready (o_bp_ready),
    .o_data  (fifo_data),
    .o_valid (fifo_valid),
    .i_ready (mem_ready)
  );

  // ####################################################################
  // Register block.
  // ####################################################################

  // The FIFO byte lands on the union port and is decoded there.
  bp_reg_mem #(
    .N_REG      (BP_N_REG)
  ) u_reg_mem (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_cg       (i_cg),
    .i_bp_data  (fifo_data),
    .i_bp_valid (fifo_valid),
    .o_bp_ready (mem_ready),
    .o_bp_data  (o_bp_data),
    .o_bp_valid (o_bp_valid),
    .i_bp_ready (i_bp_ready)
  );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk,    // Free running testbench clock.
  output logic o_rst_n   // Synchronous active low reset for the DUT.
);

  localparam int HALF_PERIOD  = 5;  // Half of the 10 ns period.
  localparam int RESET_CYCLES = 5;  // Rising edges seen with reset low.

  initial begin
    o_clk = 1'b0;                          // Known level before the first edge.
    forever #HALF_PERIOD o_clk = ~o_clk;   // Toggle every half period.
  end

  initial begin
    o_rst_n = 1'b0;                            // Reset is active from time zero.
    repeat (RESET_CYCLES) @(posedge o_clk);    // Hold it over the reset edges.
    #1;                                        // Release just after an edge, like other inputs.
    o_rst_n = 1'b1;
  end

endmodule

/* tb_bp_top.sv */
`timescale 1ns/1ps

module tb_bp_top import bp_pkg::*; ();

  // ####################################################################
  // Limits, clock and DUT.
  // ####################################################################

  localparam int    SEED        = 32'h3b18;                // Fixed seed for the reply stalls.
  localparam int    WAIT_LIMIT  = 200;                     // Cycles any single wait may take.
  localparam int    RESET_LIMIT = 20;                      // Cycles allowed for reset release.
  localparam int    IDX_W       = $clog2(BP_N_REG);        // Index bits of the register model.
  localparam string VEC_FILE    = "bp_input_vectors.txt";  // Stimulus and expected replies.

  logic                 clk;        // Testbench clock.
  logic                 rst_n;      // Reset from the clock generator.
  logic                 cg;         // Clock enable of the register block.
  logic [BP_DATA_W-1:0] in_data;    // Host byte into the FIFO.
  logic                 in_valid;
  logic                 in_ready;
  logic [BP_DATA_W-1:0] out_data;   // Reply byte to the host.
  logic                 out_valid;
  logic                 out_ready;

  logic [BP_DATA_W-1:0] exp_q [$];   // Expected replies in issue order.
  bit                   care_q [$];  // Low where the reply is undefined.
  string                name_q [$];  // Test name of each outstanding reply.
  bit                   saw_full;    // Host input was refused while the block ran.

  logic [BP_DATA_W-1:0]       model_regs [BP_N_REG];   // Register model.
  bit                         model_known [BP_N_REG];  // Register written since reset.
  logic [BP_ADDR_FIELD_W-1:0] model_addr;              // Address of the last command.
  bit                         model_in_range;          // Held address is implemented.

  tb_clk_gen u_clk_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  bp_top uut (
    .i_clk      (clk),
    .i_rst_n    (rst_n),
    .i_cg       (cg),
    .i_bp_data  (in_data),
    .i_bp_valid (in_valid),
    .o_bp_ready (in_ready),
    .o_bp_data  (out_data),
    .o_bp_valid (out_valid),
    .i_bp_ready (out_ready)
  );

  // ####################################################################
  // Reporting and timing helpers.
  // ####################################################################

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "%s", msg);
  endtask

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("mismatch %s expected=%0h actual=%0h", test_name, expected, actual));
    end
  endtask

  task automatic next_drive_point();
    @(posedge clk);  // Inputs change a little after the edge.
    #1;
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1) begin
      if (cycles == RESET_LIMIT) begin
        fail_run("Timeout: the reset was never released.");
      end
      next_drive_point();
      cycles++;
    end
  endtask

  task automatic wait_replies_done(input string test_name);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0) begin
      if (cycles == WAIT_LIMIT) begin
        fail_run($sformatf("Timeout: replies up to %s never came back.", test_name));
      end
      next_drive_point();
      cycles++;
    end
  endtask

  // Holds one byte on the host input until the FIFO takes it.
  task automatic drive_byte(input logic [BP_DATA_W-1:0] value, input string test_name);
    int cycles;
    bit taken;
    cycles   = 0;
    taken    = 1'b0;
    in_data  = value;
    in_valid = 1'b1;
    while (!taken) begin
      if (cycles == WAIT_LIMIT) begin
        fail_run($sformatf("Timeout: a byte of %s was never accepted by the FIFO.", test_name));
      end
      @(negedge clk);     // Ready is stable until the next edge.
      taken = in_ready;
      next_drive_point();
      cycles++;
    end
    in_valid = 1'b0;
  endtask

  // ####################################################################
  // Register model.
  // ####################################################################

  task automatic model_step(input bit is_wr, input logic [BP_ADDR_FIELD_W-1:0] addr,
                            input logic [BP_DATA_W-1:0] data,
                            output logic [BP_DATA_W-1:0] reply, output bit known);
    if (is_wr) begin
      model_addr     = addr;                                  // A write targets its own address.
      model_in_range = ({1'b0, addr} < 8'(BP_N_REG));
    end
    if (model_in_range) begin
      reply = model_regs[model_addr[IDX_W-1:0]];              // Old contents come back.
      known = model_known[model_addr[IDX_W-1:0]];
    end else begin
      reply = 8'h00;                                          // Missing registers read as zero.
      known = 1'b1;
    end
    if (is_wr && model_in_range) begin
      model_regs[model_addr[IDX_W-1:0]]  = data;
      model_known[model_addr[IDX_W-1:0]] = 1'b1;
    end
    if (!is_wr) begin
      model_addr     = addr;                                  // Named register replies next time.
      model_in_range = ({1'b0, addr} < 8'(BP_N_REG));
    end
  endtask

  // ####################################################################
  // Stimulus.
  // ####################################################################

  task automatic run_transaction(input string test_name, input bit is_wr,
                                 input logic [7:0] addr, input logic [7:0] data,
                                 input bit file_care, input logic [7:0] file_exp);
    bp_byte_u             cmd_byte;
    logic [BP_DATA_W-1:0] reply;
    bit                   known;
    model_step(is_wr, addr[BP_ADDR_FIELD_W-1:0], data, reply, known);
    if (known != file_care) begin
      fail_run($sformatf("The vector file and the model disagree on whether %s has a defined reply.",
                         test_name));
    end
    if (known) begin
      check_value({test_name, " vector"}, 32'(reply), 32'(file_exp));  // Catches file typos.
    end
    exp_q.push_back(reply);
    care_q.push_back(known);
    name_q.push_back(test_name);
    cmd_byte.cmd.wr   = is_wr;
    cmd_byte.cmd.addr = addr[BP_ADDR_FIELD_W-1:0];
    drive_byte(cmd_byte.data, test_name);
    if (is_wr) begin
      drive_byte(data, test_name);  // Write data follows its command.
    end
  endtask

  task automatic run_pause(input string test_name, input logic [7:0] cycles, input bit flag,
                           input logic [7:0] exp_ready);
    if (!flag) begin
      wait_replies_done(test_name);  // Freeze an idle block.
      @(negedge clk);
      check_value({test_name, " ready"}, 32'(exp_ready), 32'(in_ready));
      next_drive_point();
      cg = 1'b0;
      repeat (cycles) next_drive_point();
    end else begin
      repeat (cycles) next_drive_point();  // Bytes queued meanwhile stay in the FIFO.
      @(negedge clk);
      check_value({test_name, " ready"}, 32'(exp_ready), 32'(in_ready));
      next_drive_point();
      cg = 1'b1;
    end
  endtask

  initial begin : stimulus
    int                   fd;
    int                   n;
    string                line;
    string                name_s;
    string                op_s;
    string                exp_s;
    logic [7:0]           addr_v;
    logic [7:0]           data_v;
    logic [7:0]           exp_val;
    bit                   file_care;
    cg          = 1'b1;
    in_data     = '0;
    in_valid    = 1'b0;
    saw_full    = 1'b0;
    for (int i = 0; i < BP_N_REG; i++) begin
      model_known[i] = 1'b0;  // Registers have no reset.
    end
    model_addr     = '0;
    model_in_range = 1'b0;    // First read after reset returns zero.
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      fail_run("The vector file bp_input_vectors.txt could not be opened.");
    end
    wait_reset_release();
    @(negedge clk);
    check_value("reset_valid", 32'd0, 32'(out_valid));
    check_value("reset_ready", 32'd1, 32'(in_ready));
    next_drive_point();
    while ($fgets(line, fd) != 0) begin
      if (line.substr(0, 0) != "#") begin
        n = $sscanf(line, "%s %s %h %h %s", name_s, op_s, addr_v, data_v, exp_s);
        if (n == 5) begin
          file_care = (exp_s != "xx");
          exp_val   = '0;
          if (file_care) begin
            n = $sscanf(exp_s, "%h", exp_val);
          end
          if (op_s == "W" || op_s == "R") begin
            run_transaction(name_s, op_s == "W", addr_v, data_v, file_care, exp_val);
          end else if (op_s == "P") begin
            run_pause(name_s, addr_v, data_v[0], exp_val);
          end else begin
            fail_run($sformatf("Unknown operation %s in the vector file.", op_s));
          end
        end else if (n > 0) begin
          fail_run($sformatf("Malformed line in the vector file: %s", line));
        end
      end
    end
    $fclose(fd);
    wait_replies_done("end_of_vectors");
    repeat (10) next_drive_point();  // Any extra reply shows up here.
    check_value("backpressure_seen", 32'd1, 32'(saw_full));
    $display("Result: PASSED");
    $finish;
  end

  // ####################################################################
  // Reply consumer.
  // ####################################################################

  initial begin : reply_consumer
    int                   burst_left;
    logic [BP_DATA_W-1:0] expected;
    bit                   care;
    string                tname;
    void'($urandom(SEED));
    out_ready  = 1'b0;
    burst_left = 0;
    wait_reset_release();
    forever begin
      @(negedge clk);  // Handshake values hold until the coming edge.
      if (out_valid && !cg) begin
        fail_run("A reply became valid while the register block was frozen.");
      end
      if (!in_ready && cg) begin
        saw_full = 1'b1;  // FIFO filled under back-pressure.
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          fail_run("A reply arrived with no transaction outstanding.");
        end else begin
          expected = exp_q.pop_front();
          care     = care_q.pop_front();
          tname    = name_q.pop_front();
          if (care) begin
            check_value(tname, 32'(expected), 32'(out_data));
          end
        end
      end
      next_drive_point();
      if (burst_left > 0) begin
        out_ready = 1'b0;  // Long stall in progress.
        burst_left--;
      end else if ($urandom_range(7, 0) == 0) begin
        burst_left = $urandom_range(10, 5);  // Long enough to fill the FIFO.
        out_ready  = 1'b0;
      end else begin
        out_ready = ($urandom_range(3, 0) != 0);
      end
    end
  end

endmodule

/* bp_input_vectors.txt */
# Columns: test_name op addr data expected, numbers in hex, xx marks an undefined reply.
# op P: addr is a wait in cycles, data is the new i_cg, expected is o_bp_ready at that point.
rd_after_reset   R 00 00 00
init_w00         W 00 10 xx
init_w01         W 01 21 xx
init_w02         W 02 32 xx
init_w03         W 03 43 xx
init_w04         W 04 54 xx
init_w05         W 05 65 xx
init_w06         W 06 76 xx
init_w07         W 07 87 xx
init_w08         W 08 98 xx
init_w09         W 09 a9 xx
init_w0a         W 0a ba xx
init_w0b         W 0b cb xx
init_w0c         W 0c dc xx
init_w0d         W 0d ed xx
init_w0e         W 0e fe xx
init_w0f         W 0f 0f xx
init_w3f         W 3f 3c xx
wr_ret_old       W 05 a5 65
rd_same          R 05 00 a5
rd_next          R 06 00 a5
wr_ret_old2      W 0a 5a ba
rd_after_wr      R 0a 00 5a
rd_follow        R 00 00 5a
rs_00            R 01 00 10
rs_01            R 02 00 21
rs_02            R 03 00 32
rs_03            R 04 00 43
rs_04            R 05 00 54
rs_05            R 06 00 a5
rs_06            R 07 00 76
rs_07            R 08 00 87
rs_08            R 09 00 98
rs_09            R 0a 00 a9
rs_0a            R 0b 00 5a
rs_0b            R 0c 00 cb
rs_0c            R 0d 00 dc
rs_0d            R 0e 00 ed
rs_0e            R 0f 00 fe
rs_0f            R 3f 00 0f
rs_3f            R 03 00 3c
oor_wr_40        W 40 ee 00
oor_rd_40        R 40 00 00
oor_rd_next      R 7f 00 00
oor_wr_7f        W 7f 99 00
oor_wr_64        W 64 12 00
oor_rd_3f        R 3f 00 00
oor_rd_chk       R 40 00 3c
oor_rd_00        R 00 00 00
oor_no_alias     R 01 00 10
oor_wr_41        W 41 77 00
oor_alias01      R 01 00 00
oor_check01      R 02 00 21
cg_off           P 03 00 01
pause_wr         W 0c 3e dc
pause_rd         R 0d 00 3e
pause_rd2        R 0e 00 ed
cg_on            P 10 01 00
after_pause      R 02 00 fe
st_w00           W 00 c3 10
st_r00           R 00 00 c3
st_r01           R 01 00 c3
st_w01           W 01 3c 21
st_r02           R 02 00 3c
st_r03           R 03 00 32
st_w03           W 03 44 43
st_r04           R 04 00 44
st_r05           R 05 00 54
st_r06           R 06 00 a5
st_r07           R 07 00 76
st_r08           R 08 00 87
st_w3f           W 3f 81 3c
st_r3f           R 3f 00 81
st_r7f           R 7f 00 81
st_r09           R 09 00 00
st_r0a           R 0a 00 a9
st_end           R 00 00 5a

/* filelist.f */
bp_pkg.sv
bp_byte_fifo.sv
bp_reg_mem.sv
bp_top.sv
tb_clk_gen.sv
tb_bp_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
# The exit status is zero only when the simulation passes.

cd "$(dirname "$0")" &&
  verilator --binary --timing -f filelist.f --top-module tb_bp_top -o tb_bp_top_sim &&
  ./obj_dir/tb_bp_top_sim ||
  { echo "Simulation failed."; exit 1; }

exit 0
